// File: branch_resolve.sv
// ================================================
// Branch outcome from the datapath comparator flags
// br_lt is signed or unsigned as br_un asks
// The static guess comes in with the X word
// ================================================
`default_nettype none

module branch_resolve import rv_ctrl_pkg::*; (
  input  instr_t x_instr,
  input  logic   br_eq,
  input  logic   br_lt,
  input  logic   br_pred_taken,
  output logic   br_taken,
  output logic   br_un,
  output logic   mispredict,
  output logic   pred_wrong_taken
);

  logic is_br;

  always_comb begin
    is_br = (opc(x_instr) == OPC_BRANCH);
    br_taken = 1'b0;
    if (is_br) begin
      case (x_instr.i_s.funct3)
        FNC_BEQ:            br_taken = br_eq;
        FNC_BNE:            br_taken = !br_eq;
        FNC_BLT, FNC_BLTU:  br_taken = br_lt;
        FNC_BGE, FNC_BGEU:  br_taken = !br_lt;
        default:            br_taken = 1'b0; // 010 and 011 are not branches
      endcase
    end
    br_un            = is_br && (x_instr.i_s.funct3[2:1] == 2'b11);
    mispredict       = is_br && (br_pred_taken != br_taken);
    pred_wrong_taken = is_br && br_pred_taken && !br_taken;

    assert (is_br || !br_taken) else $error("br_taken without a branch in X");
  end

endmodule

`default_nettype wire

// File: d_stage_ctrl.sv
// ================================================
// Decode-stage control
// Forwards the WF result into D for the two-cycle hazard
// Picks the next PC; reset and redirect win over JAL
// ================================================
`default_nettype none

module d_stage_ctrl import rv_ctrl_pkg::*; (
  input  logic    rst,
  input  instr_t  d_instr,
  input  instr_t  wf_instr,
  input  logic    redirect,
  output d_ctrl_t d_ctrl
);

  logic wf_prod;

  assign wf_prod = is_producer(wf_instr);

  always_comb begin
    d_ctrl.d_fwd_a = wf_prod && (wf_instr.r.rd == d_instr.r.rs1);
    d_ctrl.d_fwd_b = wf_prod && (wf_instr.r.rd == d_instr.r.rs2);

    if (rst) begin
      d_ctrl.pc_sel = PC_RESET;
    end else if (redirect) begin
      d_ctrl.pc_sel = PC_REDIRECT; // JALR target or branch fix-up
    end else if (opc(d_instr) == OPC_JAL) begin
      d_ctrl.pc_sel = PC_JAL; // Jump resolved early in D
    end else begin
      d_ctrl.pc_sel = PC_PLUS4;
    end
  end

endmodule

`default_nettype wire

// File: instr_pipe.sv
// ================================================
// D, X and WF instruction registers
// No stall: every edge advances all three stages
// Redirect turns the D and X words into NOPs and keeps
// the redirecting word on its way into WF
// ================================================
`default_nettype none

module instr_pipe import rv_ctrl_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  instr_t fetch_instr,
  input  logic   redirect,
  output instr_t d_instr,
  output instr_t x_instr,
  output instr_t wf_instr
);

  always_ff @(posedge clk) begin
    if (rst) begin
      d_instr  <= NOP_INSTR;
      x_instr  <= NOP_INSTR;
      wf_instr <= NOP_INSTR;
    end else begin
      d_instr  <= redirect ? instr_t'(NOP_INSTR) : fetch_instr; // Wrong path
      x_instr  <= redirect ? instr_t'(NOP_INSTR) : d_instr;
      wf_instr <= x_instr;
    end
  end

  // Squashed word must never reach execute
  a_redirect_squash: assert property (
    @(posedge clk) disable iff (rst)
    redirect |=> (x_instr == NOP_INSTR)
  ) else $error("X stage not squashed after redirect");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_rv_pipe_ctrl -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?

if [ $run_status -eq 0 ] && grep -q "^No errors$" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL: see sim.log"
exit 1

// File: rv_ctrl_pkg.sv
// ================================================
// Shared constants and types for the pipeline control unit
// of a three-stage RV32I core (D, X, WF)
// Opcodes are compared on bits 6 to 2 only
// CSR instructions are not decoded
// ================================================
`default_nettype none

package rv_ctrl_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

  localparam logic [4:0] OPC_RTYPE  = 5'b01100;
  localparam logic [4:0] OPC_ITYPE  = 5'b00100;
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_LUI    = 5'b01101;

  localparam logic [2:0] FNC_ADD_SUB = 3'b000;
  localparam logic [2:0] FNC_SLL     = 3'b001;
  localparam logic [2:0] FNC_SLT     = 3'b010;
  localparam logic [2:0] FNC_SLTU    = 3'b011;
  localparam logic [2:0] FNC_XOR     = 3'b100;
  localparam logic [2:0] FNC_SRL_SRA = 3'b101;
  localparam logic [2:0] FNC_OR      = 3'b110;
  localparam logic [2:0] FNC_AND     = 3'b111;
  localparam logic [2:0] FNC_BEQ     = 3'b000;
  localparam logic [2:0] FNC_BNE     = 3'b001;
  localparam logic [2:0] FNC_BLT     = 3'b100;
  localparam logic [2:0] FNC_BGE     = 3'b101;
  localparam logic [2:0] FNC_BLTU    = 3'b110;
  localparam logic [2:0] FNC_BGEU    = 3'b111;
  localparam logic [2:0] FNC_LB      = 3'b000;
  localparam logic [2:0] FNC_LH      = 3'b001;
  localparam logic [2:0] FNC_LW      = 3'b010;
  localparam logic [2:0] FNC_LBU     = 3'b100;
  localparam logic [2:0] FNC_LHU     = 3'b101;
  localparam logic       FNC2_ALT    = 1'b1; // Bit 30, sub and sra

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_XOR  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_SLT  = 4'd8;
  localparam logic [3:0] ALU_SLTU = 4'd9;
  localparam logic [3:0] ALU_LUI  = 4'd10;
  localparam logic [3:0] ALU_FIX  = 4'd11; // pc+4 after wrong taken guess

  localparam logic [1:0] FWD_RF  = 2'd0;
  localparam logic [1:0] FWD_ALU = 2'd1;
  localparam logic [1:0] FWD_MEM = 2'd2;

  localparam logic [1:0] ASRC_RS  = 2'd0;
  localparam logic [1:0] ASRC_PC  = 2'd1;
  localparam logic [1:0] ASRC_MEM = 2'd2;

  localparam logic [1:0] WB_MEM = 2'd0;
  localparam logic [1:0] WB_ALU = 2'd1;
  localparam logic [1:0] WB_PC4 = 2'd2;

  localparam logic [2:0] LDX_W  = 3'd0;
  localparam logic [2:0] LDX_HU = 3'd1;
  localparam logic [2:0] LDX_H  = 3'd2;
  localparam logic [2:0] LDX_BU = 3'd3;
  localparam logic [2:0] LDX_B  = 3'd4;

  localparam logic [2:0] PC_RESET    = 3'd0;
  localparam logic [2:0] PC_JAL      = 3'd1;
  localparam logic [2:0] PC_PLUS4    = 3'd2;
  localparam logic [2:0] PC_REDIRECT = 3'd3;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]       imm_hi; // I immediate, or S imm[11:5] with rs2
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_lo; // Store imm[4:0], rd elsewhere
    logic [6:0]        opcode;
  } is_fmt_t;

  typedef union packed {
    r_fmt_t  r;
    is_fmt_t i_s;
  } instr_t;

  typedef struct packed {
    logic [2:0] pc_sel;
    logic       d_fwd_a;
    logic       d_fwd_b;
  } d_ctrl_t;

  typedef struct packed {
    logic [3:0] alu_sel;
    logic [1:0] a_sel;
    logic       b_sel; // 1 selects the immediate
    logic       br_un;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
    logic [1:0] rs2_sel;
    logic       br_taken;
  } x_ctrl_t;

  typedef struct packed {
    logic       rf_we;
    logic [1:0] wb_sel;
    logic [2:0] ldx_sel;
  } wf_ctrl_t;

  function automatic logic [4:0] opc(input instr_t instr);
    return instr.r.opcode[6:2];
  endfunction

  // True when the word can supply a result to a later reader
  function automatic logic is_producer(input instr_t instr);
    return (opc(instr) != OPC_BRANCH) && (opc(instr) != OPC_STORE) &&
           (instr.r.rd != '0);
  endfunction

endpackage

`default_nettype wire

// File: rv_pipe_ctrl.sv
// ================================================
// Pipeline control unit, top level
// All outputs are combinational from the stage registers
// and the comparator flags; flush is the X redirect
// ================================================
`default_nettype none

module rv_pipe_ctrl import rv_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  instr_t   fetch_instr,
  input  logic     br_eq,
  input  logic     br_lt,
  input  logic     br_pred_taken,
  output d_ctrl_t  d_ctrl,
  output x_ctrl_t  x_ctrl,
  output wf_ctrl_t wf_ctrl,
  output logic     flush
);

  instr_t d_instr;
  instr_t x_instr;
  instr_t wf_instr;
  logic   redirect;

  instr_pipe i_instr_pipe (
    .clk         (clk),
    .rst         (rst),
    .fetch_instr (fetch_instr),
    .redirect    (redirect),
    .d_instr     (d_instr),
    .x_instr     (x_instr),
    .wf_instr    (wf_instr)
  );

  d_stage_ctrl i_d_stage_ctrl (
    .rst      (rst),
    .d_instr  (d_instr),
    .wf_instr (wf_instr),
    .redirect (redirect),
    .d_ctrl   (d_ctrl)
  );

  x_stage_ctrl i_x_stage_ctrl (
    .x_instr       (x_instr),
    .wf_instr      (wf_instr),
    .br_eq         (br_eq),
    .br_lt         (br_lt),
    .br_pred_taken (br_pred_taken),
    .x_ctrl        (x_ctrl),
    .redirect      (redirect)
  );

  wf_stage_ctrl i_wf_stage_ctrl (
    .wf_instr (wf_instr),
    .wf_ctrl  (wf_ctrl)
  );

  assign flush = redirect;

endmodule

`default_nettype wire

// File: sources.f
rv_ctrl_pkg.sv
instr_pipe.sv
d_stage_ctrl.sv
x_forward.sv
branch_resolve.sv
x_stage_ctrl.sv
wf_stage_ctrl.sv
rv_pipe_ctrl.sv
tb_rv_pipe_ctrl.sv

// File: tb_rv_pipe_ctrl.sv
// ================================================
// Table-driven testbench for the pipeline control unit
// One table row per cycle; inputs driven 10 after the edge
// Outputs sampled 10 before the next edge
// Flags are random only where X holds no branch
// ================================================
`default_nettype none

module tb_rv_pipe_ctrl import rv_ctrl_pkg::*; ();

  typedef struct packed {
    instr_t   instr;
    logic     eq;
    logic     lt;
    logic     pred;
    logic     rnd; // Flags are don't-care in this row
    d_ctrl_t  d;
    x_ctrl_t  x;
    wf_ctrl_t wf;
    logic     flush;
  } row_t;

  logic     clk;
  logic     rst;
  instr_t   fetch_instr;
  logic     br_eq;
  logic     br_lt;
  logic     br_pred_taken;
  d_ctrl_t  d_ctrl;
  x_ctrl_t  x_ctrl;
  wf_ctrl_t wf_ctrl;
  logic     flush;

  row_t        rows[$];
  d_ctrl_t     d_p4;
  d_ctrl_t     d_rdr;
  x_ctrl_t     x_nop;
  wf_ctrl_t    w_alu;
  wf_ctrl_t    w_off;
  wf_ctrl_t    w_mem;
  instr_t      nop_w;
  logic [31:0] rnd_word;
  int          cnt;

  rv_pipe_ctrl i_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_instr   (fetch_instr),
    .br_eq         (br_eq),
    .br_lt         (br_lt),
    .br_pred_taken (br_pred_taken),
    .d_ctrl        (d_ctrl),
    .x_ctrl        (x_ctrl),
    .wf_ctrl       (wf_ctrl),
    .flush         (flush)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // R, S and B words share one field layout
  function automatic instr_t r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd, logic [4:0] op);
    return instr_t'({f7, rs2, rs1, f3, rd, op, 2'b11});
  endfunction

  function automatic instr_t i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [4:0] op);
    return instr_t'({imm, rs1, f3, rd, op, 2'b11});
  endfunction

  function automatic instr_t branch_word(logic [2:0] f3);
    return r_word(7'h00, 5'd21, 5'd20, f3, 5'd0, OPC_BRANCH); // x20 vs x21, never written
  endfunction

  function automatic instr_t load_word(logic [2:0] f3, logic [4:0] rd);
    return i_word(12'd0, 5'd2, f3, rd, OPC_LOAD);
  endfunction

  function automatic d_ctrl_t dc(logic [2:0] pc, logic fa, logic fb);
    d_ctrl_t v;
    v.pc_sel  = pc;
    v.d_fwd_a = fa;
    v.d_fwd_b = fb;
    return v;
  endfunction

  function automatic x_ctrl_t xc(logic [3:0] alu, logic [1:0] a, logic b, logic un,
                                 logic [1:0] fa, logic [1:0] fb, logic [1:0] rs2, logic tk);
    x_ctrl_t v;
    v.alu_sel  = alu;
    v.a_sel    = a;
    v.b_sel    = b;
    v.br_un    = un;
    v.fwd_a    = fa;
    v.fwd_b    = fb;
    v.rs2_sel  = rs2;
    v.br_taken = tk;
    return v;
  endfunction

  // Plain register-source op, no branch
  function automatic x_ctrl_t xa(logic [3:0] alu, logic b, logic [1:0] fa, logic [1:0] fb);
    return xc(alu, ASRC_RS, b, 1'b0, fa, fb, FWD_RF, 1'b0);
  endfunction

  function automatic x_ctrl_t xbr(logic un, logic tk);
    return xc(ALU_ADD, ASRC_PC, 1'b1, un, FWD_RF, FWD_RF, FWD_RF, tk);
  endfunction

  function automatic wf_ctrl_t wc(logic we, logic [1:0] wb, logic [2:0] ldx);
    wf_ctrl_t v;
    v.rf_we   = we;
    v.wb_sel  = wb;
    v.ldx_sel = ldx;
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at time %0t: %s is %0h, expected %0h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_outputs(input d_ctrl_t d, input x_ctrl_t x, input wf_ctrl_t w,
                               input logic fl, input string tag);
    check_val(32'(d_ctrl), 32'(d), {tag, " d_ctrl"});
    check_val(32'(x_ctrl), 32'(x), {tag, " x_ctrl"});
    check_val(32'(wf_ctrl), 32'(w), {tag, " wf_ctrl"});
    check_val(32'(flush), 32'(fl), {tag, " flush"});
  endtask

  task automatic add_row(input instr_t instr, input logic eq, input logic lt, input logic pred,
                         input logic rnd, input d_ctrl_t d, input x_ctrl_t x,
                         input wf_ctrl_t wf, input logic fl);
    row_t r;
    r.instr = instr;
    r.eq    = eq;
    r.lt    = lt;
    r.pred  = pred;
    r.rnd   = rnd;
    r.d     = d;
    r.x     = x;
    r.wf    = wf;
    r.flush = fl;
    rows.push_back(r);
  endtask

  // Row k word is in D at k+1, X at k+2, WF at k+3
  task automatic fill_table();
    add_row(r_word(7'h00, 5'd3, 5'd2, FNC_ADD_SUB, 5'd1, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, x_nop, w_alu, 0); // add x1
    add_row(r_word(7'h20, 5'd5, 5'd1, FNC_ADD_SUB, 5'd4, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, x_nop, w_alu, 0); // sub x4, uses x1
    add_row(r_word(7'h20, 5'd4, 5'd1, FNC_SRL_SRA, 5'd6, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, xa(ALU_ADD, 0, FWD_RF, FWD_RF), w_alu, 0); // sra x6, x1 and x4
    add_row(i_word(12'd5, 5'd0, FNC_SLTU, 5'd7, OPC_ITYPE), 0, 0, 0, 1,
            dc(PC_PLUS4, 1, 0), xa(ALU_SUB, 0, FWD_ALU, FWD_RF), w_alu, 0);
    add_row(i_word(12'd0, 5'd0, 3'b001, 5'd8, OPC_LUI), 0, 0, 0, 1,
            d_p4, xa(ALU_SRA, 0, FWD_RF, FWD_ALU), w_alu, 0); // lui x8, 1
    add_row(load_word(FNC_LW, 5'd9), 0, 0, 0, 1,
            d_p4, xa(ALU_SLTU, 1, FWD_RF, FWD_RF), w_alu, 0);
    add_row(r_word(7'h00, 5'd0, 5'd9, FNC_ADD_SUB, 5'd11, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, xa(ALU_LUI, 1, FWD_RF, FWD_RF), w_alu, 0);
    add_row(i_word(12'd4, 5'd2, FNC_LW, 5'd12, OPC_LOAD), 0, 0, 0, 1,
            d_p4, x_nop, w_alu, 0);
    add_row(r_word(7'h00, 5'd12, 5'd13, FNC_LW, 5'd8, OPC_STORE), 0, 0, 0, 1,
            d_p4, xa(ALU_ADD, 0, FWD_MEM, FWD_RF), w_mem, 0); // Load then use
    add_row(load_word(FNC_LW, 5'd14), 0, 0, 0, 1,
            d_p4, x_nop, w_alu, 0);
    add_row(r_word(7'h00, 5'd3, 5'd14, FNC_LW, 5'd0, OPC_STORE), 0, 0, 0, 1,
            d_p4, xc(ALU_ADD, ASRC_RS, 1, 0, FWD_RF, FWD_MEM, FWD_MEM, 0), w_mem, 0);
    add_row(r_word(7'h00, 5'd1, 5'd1, FNC_ADD_SUB, 5'd0, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, x_nop, w_off, 0); // add x0
    add_row(r_word(7'h00, 5'd0, 5'd0, FNC_ADD_SUB, 5'd15, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, xc(ALU_ADD, ASRC_MEM, 1, 0, FWD_MEM, FWD_RF, FWD_RF, 0), w_mem, 0);
    add_row(nop_w, 0, 0, 0, 1, d_p4, xa(ALU_ADD, 0, FWD_RF, FWD_RF), w_off, 0);
    add_row(r_word(7'h00, 5'd15, 5'd15, FNC_AND, 5'd17, OPC_RTYPE), 0, 0, 0, 1,
            d_p4, xa(ALU_ADD, 0, FWD_RF, FWD_RF), w_alu, 0); // x0 source, no forward
    add_row(branch_word(FNC_BEQ), 0, 0, 0, 1, dc(PC_PLUS4, 1, 1), x_nop, w_alu, 0);
    add_row(branch_word(FNC_BEQ), 0, 0, 0, 1, d_p4, xa(ALU_AND, 0, FWD_RF, FWD_RF), w_alu, 0);
    add_row(branch_word(FNC_BNE), 1, 0, 1, 0, d_p4, xbr(0, 1), w_alu, 0);
    add_row(branch_word(FNC_BNE), 0, 1, 0, 0, d_p4, xbr(0, 0), w_off, 0);
    add_row(branch_word(FNC_BLT), 0, 1, 1, 0, d_p4, xbr(0, 1), w_off, 0);
    add_row(branch_word(FNC_BLT), 1, 0, 0, 0, d_p4, xbr(0, 0), w_off, 0);
    add_row(branch_word(FNC_BGE), 0, 1, 1, 0, d_p4, xbr(0, 1), w_off, 0);
    add_row(branch_word(FNC_BGE), 1, 0, 0, 0, d_p4, xbr(0, 0), w_off, 0);
    add_row(branch_word(FNC_BLTU), 0, 0, 1, 0, d_p4, xbr(0, 1), w_off, 0);
    add_row(branch_word(FNC_BLTU), 0, 1, 0, 0, d_p4, xbr(0, 0), w_off, 0);
    add_row(branch_word(FNC_BGEU), 0, 1, 1, 0, d_p4, xbr(1, 1), w_off, 0);
    add_row(branch_word(FNC_BGEU), 1, 0, 0, 0, d_p4, xbr(1, 0), w_off, 0);
    add_row(i_word(12'd0, 5'd5, 3'b000, 5'd1, OPC_JALR), 1, 0, 1, 0, d_p4, xbr(1, 1), w_off, 0);
    add_row(i_word(12'd1, 5'd0, 3'b000, 5'd18, OPC_ITYPE), 0, 1, 0, 0,
            d_p4, xbr(1, 0), w_off, 0);
    add_row(i_word(12'd1, 5'd0, 3'b000, 5'd19, OPC_ITYPE), 0, 0, 0, 1,
            d_rdr, x_nop, w_off, 1); // JALR in X
    add_row(branch_word(FNC_BEQ), 0, 0, 0, 1, d_p4, x_nop, wc(1, WB_PC4, LDX_W), 0);
    add_row(i_word(12'd1, 5'd0, 3'b000, 5'd18, OPC_ITYPE), 0, 0, 0, 1, d_p4, x_nop, w_alu, 0);
    add_row(nop_w, 0, 0, 1, 0, d_rdr,
            xc(ALU_FIX, ASRC_PC, 1, 0, FWD_RF, FWD_RF, FWD_RF, 0), w_alu, 1);
    add_row(branch_word(FNC_BNE), 0, 0, 0, 1, d_p4, x_nop, w_off, 0);
    add_row(i_word(12'd1, 5'd0, 3'b000, 5'd19, OPC_ITYPE), 0, 0, 0, 1, d_p4, x_nop, w_alu, 0);
    add_row(nop_w, 0, 0, 0, 0, d_rdr, xbr(0, 1), w_alu, 1); // Taken, guessed not taken
    add_row(load_word(FNC_LB, 5'd22), 0, 0, 0, 1, d_p4, x_nop, w_off, 0);
    add_row(load_word(FNC_LBU, 5'd23), 0, 0, 0, 1, d_p4, x_nop, w_alu, 0);
    add_row(load_word(FNC_LH, 5'd24), 0, 0, 0, 1, d_p4, x_nop, w_alu, 0);
    add_row(load_word(FNC_LHU, 5'd25), 0, 0, 0, 1, d_p4, x_nop, wc(1, WB_MEM, LDX_B), 0);
    add_row(load_word(FNC_LW, 5'd26), 0, 0, 0, 1, d_p4, x_nop, wc(1, WB_MEM, LDX_BU), 0);
    add_row(i_word(12'd0, 5'd0, 3'b000, 5'd1, OPC_JAL), 0, 0, 0, 1,
            d_p4, x_nop, wc(1, WB_MEM, LDX_H), 0);
    add_row(nop_w, 0, 0, 0, 1, dc(PC_JAL, 0, 0), x_nop, wc(1, WB_MEM, LDX_HU), 0);
    add_row(nop_w, 0, 0, 0, 1, d_p4,
            xc(ALU_ADD, ASRC_PC, 1, 0, FWD_RF, FWD_RF, FWD_RF, 0), w_mem, 0);
    add_row(nop_w, 0, 0, 0, 1, d_p4, x_nop, wc(1, WB_PC4, LDX_W), 0);
  endtask

  initial begin
    rst           = 1'b1;
    fetch_instr   = NOP_INSTR;
    br_eq         = 1'b0;
    br_lt         = 1'b0;
    br_pred_taken = 1'b0;
    rnd_word      = $urandom(35027);
    nop_w = instr_t'(NOP_INSTR);
    d_p4  = dc(PC_PLUS4, 0, 0);
    d_rdr = dc(PC_REDIRECT, 0, 0);
    x_nop = xa(ALU_ADD, 1, FWD_RF, FWD_RF); // addi x0 decode
    w_alu = wc(1, WB_ALU, LDX_W);
    w_off = wc(0, WB_ALU, LDX_W);
    w_mem = wc(1, WB_MEM, LDX_W);
    fill_table();

    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      #10;
      if (i == 4) begin
        rst = 1'b0;
      end else begin
        #80;
        check_outputs(dc(PC_RESET, 0, 0), x_nop, w_alu, 1'b0, "reset");
      end
    end

    cnt = 0;
    while (d_ctrl.pc_sel == PC_RESET) begin
      if (cnt >= 10) begin
        abort_run("pc_sel stayed at PC_RESET after reset was released");
      end
      cnt++;
      #1;
    end

    for (int r = 0; r < rows.size(); r++) begin
      fetch_instr = rows[r].instr;
      if (rows[r].rnd) begin
        rnd_word      = $urandom();
        br_eq         = rnd_word[0];
        br_lt         = rnd_word[1];
        br_pred_taken = rnd_word[2];
      end else begin
        br_eq         = rows[r].eq;
        br_lt         = rows[r].lt;
        br_pred_taken = rows[r].pred;
      end
      #80;
      check_outputs(rows[r].d, rows[r].x, rows[r].wf, rows[r].flush,
                    $sformatf("row %0d", r));
      @(posedge clk);
      #10;
    end

    $display("No errors");
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #20000;
    abort_run("Simulation did not finish in time");
  end

endmodule

`default_nettype wire

// File: wf_stage_ctrl.sv
// ================================================
// Writeback control for the WF word
// Stores, branches and unknown opcodes do not write
// ================================================
`default_nettype none

module wf_stage_ctrl import rv_ctrl_pkg::*; (
  input  instr_t   wf_instr,
  output wf_ctrl_t wf_ctrl
);

  always_comb begin
    wf_ctrl.ldx_sel = LDX_W;
    case (opc(wf_instr))
      OPC_RTYPE, OPC_ITYPE, OPC_AUIPC, OPC_LUI: begin
        wf_ctrl.rf_we  = 1'b1;
        wf_ctrl.wb_sel = WB_ALU;
      end
      OPC_LOAD: begin
        wf_ctrl.rf_we  = 1'b1;
        wf_ctrl.wb_sel = WB_MEM;
        case (wf_instr.i_s.funct3)
          FNC_LB:  wf_ctrl.ldx_sel = LDX_B;
          FNC_LBU: wf_ctrl.ldx_sel = LDX_BU;
          FNC_LH:  wf_ctrl.ldx_sel = LDX_H;
          FNC_LHU: wf_ctrl.ldx_sel = LDX_HU;
          FNC_LW:  wf_ctrl.ldx_sel = LDX_W;
          default: wf_ctrl.ldx_sel = LDX_W;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        wf_ctrl.rf_we  = 1'b1;
        wf_ctrl.wb_sel = WB_PC4; // Link address
      end
      default: begin
        wf_ctrl.rf_we  = 1'b0;
        wf_ctrl.wb_sel = WB_ALU;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: x_forward.sv
// ================================================
// Execute-stage forwarding selects
// Producer is the WF word; x0 never forwards
// Store data and store base get their own selects
// ================================================
`default_nettype none

module x_forward import rv_ctrl_pkg::*; (
  input  instr_t     x_instr,
  input  instr_t     wf_instr,
  output logic [1:0] fwd_a,
  output logic [1:0] fwd_b,
  output logic [1:0] rs2_sel,
  output logic       mem_to_rs1
);

  logic       wf_prod;
  logic       wf_load;
  logic       x_store;
  logic       hit_a;
  logic       hit_b;
  logic [1:0] src;

  always_comb begin
    wf_prod = is_producer(wf_instr);
    wf_load = (opc(wf_instr) == OPC_LOAD);
    x_store = (opc(x_instr) == OPC_STORE);
    hit_a   = wf_prod && (wf_instr.r.rd == x_instr.r.rs1);
    hit_b   = wf_prod && (wf_instr.r.rd == x_instr.r.rs2);
    src     = wf_load ? FWD_MEM : FWD_ALU; // Load data or ALU result

    fwd_a      = hit_a ? src : FWD_RF;
    fwd_b      = hit_b ? src : FWD_RF;
    rs2_sel    = (x_store && hit_b) ? src : FWD_RF;
    mem_to_rs1 = x_store && wf_load && wf_prod &&
                 (wf_instr.r.rd == x_instr.i_s.rs1); // Base from load data

    // Memory data only exists behind a load in WF
    assert ((fwd_a != FWD_MEM && fwd_b != FWD_MEM && rs2_sel != FWD_MEM) ||
            opc(wf_instr) == OPC_LOAD)
      else $error("FWD_MEM without a load in WF");
  end

endmodule

`default_nettype wire

// File: x_stage_ctrl.sv
// ================================================
// Execute-stage control: ALU op, operand sources,
// forwarding and branch resolution
// redirect flushes D and X; JALR always redirects
// ================================================
`default_nettype none

module x_stage_ctrl import rv_ctrl_pkg::*; (
  input  instr_t  x_instr,
  input  instr_t  wf_instr,
  input  logic    br_eq,
  input  logic    br_lt,
  input  logic    br_pred_taken,
  output x_ctrl_t x_ctrl,
  output logic    redirect
);

  logic       mem_to_rs1;
  logic       mispredict;
  logic       pred_wrong_taken;
  logic [3:0] arith_sel;
  logic       alt;

  x_forward i_x_forward (
    .x_instr    (x_instr),
    .wf_instr   (wf_instr),
    .fwd_a      (x_ctrl.fwd_a),
    .fwd_b      (x_ctrl.fwd_b),
    .rs2_sel    (x_ctrl.rs2_sel),
    .mem_to_rs1 (mem_to_rs1)
  );

  branch_resolve i_branch_resolve (
    .x_instr          (x_instr),
    .br_eq            (br_eq),
    .br_lt            (br_lt),
    .br_pred_taken    (br_pred_taken),
    .br_taken         (x_ctrl.br_taken),
    .br_un            (x_ctrl.br_un),
    .mispredict       (mispredict),
    .pred_wrong_taken (pred_wrong_taken)
  );

  // Shared funct3 decode of R-type and I-type arithmetic
  always_comb begin
    alt = (x_instr.r.funct7[5] == FNC2_ALT);
    case (x_instr.r.funct3)
      FNC_ADD_SUB: arith_sel = (alt && opc(x_instr) == OPC_RTYPE) ? ALU_SUB : ALU_ADD;
      FNC_SLL:     arith_sel = ALU_SLL;
      FNC_SLT:     arith_sel = ALU_SLT;
      FNC_SLTU:    arith_sel = ALU_SLTU;
      FNC_XOR:     arith_sel = ALU_XOR;
      FNC_SRL_SRA: arith_sel = alt ? ALU_SRA : ALU_SRL; // srai keeps bit 30
      FNC_OR:      arith_sel = ALU_OR;
      default:     arith_sel = ALU_AND;
    endcase
  end

  always_comb begin
    case (opc(x_instr))
      OPC_RTYPE, OPC_ITYPE: x_ctrl.alu_sel = arith_sel;
      OPC_BRANCH:           x_ctrl.alu_sel = pred_wrong_taken ? ALU_FIX : ALU_ADD;
      OPC_LUI:              x_ctrl.alu_sel = ALU_LUI;
      default:              x_ctrl.alu_sel = ALU_ADD; // Address and target sums
    endcase

    x_ctrl.b_sel = (opc(x_instr) != OPC_RTYPE);

    if (opc(x_instr) == OPC_BRANCH || opc(x_instr) == OPC_JAL ||
        opc(x_instr) == OPC_AUIPC) begin
      x_ctrl.a_sel = ASRC_PC;
    end else if (mem_to_rs1) begin
      x_ctrl.a_sel = ASRC_MEM;
    end else begin
      x_ctrl.a_sel = ASRC_RS;
    end
  end

  assign redirect = (opc(x_instr) == OPC_JALR) || mispredict;

endmodule

`default_nettype wire
